// File: hdl/muldiv_settings.svh
// muldiv settings: data width, tag width and divider step count
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// operand and result width
`define MULDIV_XLEN      32

// request tag width, returned unchanged with the result
`define MULDIV_TAG_W     4

// one restoring step per quotient bit
`define MULDIV_DIV_STEPS `MULDIV_XLEN

`endif

// File: hdl/muldiv_op_pkg.sv
// muldiv operation package: RV32M operation codes and per-unit control structs
`default_nettype none

package muldiv_op_pkg;

    // ------------------------------------------------------------------------
    // operation codes, same values as the RV32M funct3 field
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,  // low word of product
        OP_MULH   = 3'b001,  // signed x signed, high word
        OP_MULHSU = 3'b010,  // signed x unsigned, high word
        OP_MULHU  = 3'b011,  // unsigned x unsigned, high word
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_e;

    // ------------------------------------------------------------------------
    // unit controls
    // ------------------------------------------------------------------------

    // multiplier control
    typedef struct packed {
        logic src1_signed;  // sign-extend src1 to 33 bits
        logic src2_signed;  // sign-extend src2 to 33 bits
        logic high;         // return upper half of product
    } mul_ctrl_t;

    // divider control
    typedef struct packed {
        logic is_signed;    // operands are two's complement
        logic is_rem;       // return remainder, not quotient
    } div_ctrl_t;

endpackage

`default_nettype wire

// File: hdl/muldiv_bus_pkg.sv
// muldiv bus package: request and response structs at the unit boundary
`default_nettype none

`include "muldiv_settings.svh"

package muldiv_bus_pkg;
    import muldiv_op_pkg::*;

    typedef logic [`MULDIV_XLEN-1:0]  xword_t;  // data word
    typedef logic [`MULDIV_TAG_W-1:0] tag_t;    // request tag

    // request into the unit, 71 bits
    typedef struct packed {
        muldiv_op_e op;
        xword_t     src1;   // rs1 operand, dividend for divides
        xword_t     src2;   // rs2 operand, divisor for divides
        tag_t       tag;
    } muldiv_req_t;

    // response out of the unit, 36 bits
    typedef struct packed {
        xword_t rslt;
        tag_t   tag;        // copied from the request
    } muldiv_rsp_t;

endpackage

`default_nettype wire

// File: hdl/pipe_slice.sv
// pipe slice: one-entry valid/ready register stage for any payload type
`default_nettype none

module pipe_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst,
    // upstream side
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    // downstream side
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     full_q;
    payload_t data_q;
    logic     in_fire;

    // empty, or draining in this same cycle
    assign in_ready_o  = !full_q || out_ready_i;
    assign in_fire     = in_valid_i && in_ready_o;

    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (in_fire) begin
            full_q <= 1'b1;
        end else if (out_ready_i) begin
            full_q <= 1'b0;  // taken, nothing new behind it
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            data_q <= in_data_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/multiplier.sv
// multiplier: two-step 33x33 signed multiply, result held until acknowledged
`default_nettype none

`include "muldiv_settings.svh"

module multiplier
    import muldiv_op_pkg::*;
    import muldiv_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst,
    input  logic      start_i,
    input  mul_ctrl_t ctrl_i,
    input  xword_t    src1_i,
    input  xword_t    src2_i,
    output logic      busy_o,
    output logic      done_o,
    input  logic      ack_i,
    output xword_t    rslt_o
);

    localparam int XLEN   = `MULDIV_XLEN;
    localparam int PROD_W = 2 * XLEN;

    typedef enum logic [1:0] {MUL_IDLE, MUL_EXEC, MUL_RET} mul_state_e;

    mul_state_e              state_q;
    mul_state_e              state_d;
    logic signed [XLEN:0]    op_a_q;   // extended src1
    logic signed [XLEN:0]    op_b_q;   // extended src2
    logic        [PROD_W-1:0] prod_q;
    logic                    high_q;

    always_comb begin
        case (state_q)
            MUL_IDLE: state_d = start_i ? MUL_EXEC : MUL_IDLE;
            MUL_EXEC: state_d = MUL_RET;
            MUL_RET:  state_d = ack_i ? MUL_IDLE : MUL_RET;
            default:  state_d = MUL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            state_q <= MUL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == MUL_IDLE && start_i) begin
            op_a_q <= {ctrl_i.src1_signed & src1_i[XLEN-1], src1_i};
            op_b_q <= {ctrl_i.src2_signed & src2_i[XLEN-1], src2_i};
            high_q <= ctrl_i.high;
        end
        if (state_q == MUL_EXEC) begin
            prod_q <= PROD_W'(op_a_q) * PROD_W'(op_b_q);  // low 64 bits suffice
        end
    end

    assign busy_o = (state_q != MUL_IDLE);
    assign done_o = (state_q == MUL_RET);
    assign rslt_o = high_q ? prod_q[PROD_W-1:XLEN] : prod_q[XLEN-1:0];

endmodule

`default_nettype wire

// File: hdl/divider.sv
// divider: bit-serial restoring divide with sign fix-up and divide-by-zero result
`default_nettype none

`include "muldiv_settings.svh"

module divider
    import muldiv_op_pkg::*;
    import muldiv_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst,
    input  logic      start_i,
    input  div_ctrl_t ctrl_i,
    input  xword_t    src1_i,
    input  xword_t    src2_i,
    output logic      busy_o,
    output logic      done_o,
    input  logic      ack_i,
    output xword_t    rslt_o
);

    localparam int XLEN  = `MULDIV_XLEN;
    localparam int STEPS = `MULDIV_DIV_STEPS;
    localparam int CNT_W = $clog2(STEPS);

    typedef enum logic [1:0] {DIV_IDLE, DIV_CHECK, DIV_EXEC, DIV_RET} div_state_e;

    div_state_e       state_q;
    div_state_e       state_d;
    logic [CNT_W-1:0] cnt_q;       // steps left minus one

    xword_t           rem_q;       // dividend until check, then partial remainder
    xword_t           quo_q;       // dividend magnitude shifting out, quotient in
    xword_t           dvsr_q;
    logic             is_rem_q;
    logic             dvnd_neg_q;
    logic             dvsr_neg_q;
    logic             quo_neg_q;   // negate quotient on return
    logic             rem_neg_q;   // negate remainder on return

    xword_t           dvnd_mag;
    xword_t           dvsr_mag;
    logic             dvsr_zero;
    logic [XLEN:0]    shifted;
    logic [XLEN+1:0]  diff;
    logic             fits;

    assign dvnd_mag  = dvnd_neg_q ? -rem_q : rem_q;
    assign dvsr_mag  = dvsr_neg_q ? -dvsr_q : dvsr_q;
    assign dvsr_zero = (dvsr_q == '0);

    // one restoring step
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvsr_q};
    assign fits    = !diff[XLEN+1];  // no borrow

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------
    always_comb begin
        case (state_q)
            DIV_IDLE:  state_d = start_i ? DIV_CHECK : DIV_IDLE;
            DIV_CHECK: state_d = dvsr_zero ? DIV_RET : DIV_EXEC;  // zero short-cut
            DIV_EXEC:  state_d = (cnt_q == '0) ? DIV_RET : DIV_EXEC;
            DIV_RET:   state_d = ack_i ? DIV_IDLE : DIV_RET;
            default:   state_d = DIV_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == DIV_CHECK) begin
                cnt_q <= CNT_W'(STEPS - 1);
            end else if (state_q == DIV_EXEC) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        case (state_q)
            DIV_IDLE: begin
                if (start_i) begin
                    rem_q      <= src1_i;
                    dvsr_q     <= src2_i;
                    is_rem_q   <= ctrl_i.is_rem;
                    dvnd_neg_q <= ctrl_i.is_signed & src1_i[XLEN-1];
                    dvsr_neg_q <= ctrl_i.is_signed & src2_i[XLEN-1];
                    quo_neg_q  <= ctrl_i.is_signed & (src1_i[XLEN-1] ^ src2_i[XLEN-1]);
                    rem_neg_q  <= ctrl_i.is_signed & src1_i[XLEN-1];
                end
            end
            DIV_CHECK: begin
                if (dvsr_zero) begin
                    quo_q     <= '1;    // all ones, remainder keeps dividend
                    quo_neg_q <= 1'b0;
                    rem_neg_q <= 1'b0;
                end else begin
                    rem_q  <= '0;
                    quo_q  <= dvnd_mag;
                    dvsr_q <= dvsr_mag;
                end
            end
            DIV_EXEC: begin
                rem_q <= fits ? diff[XLEN-1:0] : shifted[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], fits};
            end
            default: begin
            end
        endcase
    end

    assign busy_o = (state_q != DIV_IDLE);
    assign done_o = (state_q == DIV_RET);
    assign rslt_o = is_rem_q ? (rem_neg_q ? -rem_q : rem_q)
                             : (quo_neg_q ? -quo_q : quo_q);

endmodule

`default_nettype wire

// File: hdl/muldiv_dispatch.sv
// muldiv dispatch: decodes a request, starts one unit and returns its tagged result
`default_nettype none

module muldiv_dispatch
    import muldiv_op_pkg::*;
    import muldiv_bus_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst,
    // request from input slice
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  muldiv_req_t req_i,
    // unit controls and operands
    output logic        mul_start_o,
    output mul_ctrl_t   mul_ctrl_o,
    output logic        div_start_o,
    output div_ctrl_t   div_ctrl_o,
    output xword_t      src1_o,
    output xword_t      src2_o,
    // multiplier status
    input  logic        mul_busy_i,
    input  logic        mul_done_i,
    input  xword_t      mul_rslt_i,
    output logic        mul_ack_o,
    // divider status
    input  logic        div_busy_i,
    input  logic        div_done_i,
    input  xword_t      div_rslt_i,
    output logic        div_ack_o,
    // response to output slice
    output logic        rsp_valid_o,
    input  logic        rsp_ready_i,
    output muldiv_rsp_t rsp_o
);

    logic      busy_q;     // an operation is owned by dispatch
    logic      start_q;    // start pulse, cycle after accept
    logic      sel_div_q;  // divider owns the operation
    mul_ctrl_t mul_ctrl_q;
    div_ctrl_t div_ctrl_q;
    xword_t    src1_q;
    xword_t    src2_q;
    tag_t      tag_q;

    mul_ctrl_t mul_ctrl_d;
    div_ctrl_t div_ctrl_d;
    logic      is_div_op;
    logic      accept;
    logic      unit_done;
    logic      rsp_fire;

    // ------------------------------------------------------------------------
    // funct3 decode
    // ------------------------------------------------------------------------
    always_comb begin
        is_div_op              = req_i.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        mul_ctrl_d.src1_signed = (req_i.op == OP_MULH) || (req_i.op == OP_MULHSU);
        mul_ctrl_d.src2_signed = (req_i.op == OP_MULH);
        mul_ctrl_d.high        = (req_i.op != OP_MUL);
        div_ctrl_d.is_signed   = (req_i.op == OP_DIV) || (req_i.op == OP_REM);
        div_ctrl_d.is_rem      = (req_i.op == OP_REM) || (req_i.op == OP_REMU);
    end

    assign req_ready_o = !busy_q && !mul_busy_i && !div_busy_i;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            busy_q    <= 1'b0;
            start_q   <= 1'b0;
            sel_div_q <= 1'b0;
        end else begin
            start_q <= accept;
            if (accept) begin
                busy_q    <= 1'b1;
                sel_div_q <= is_div_op;
            end else if (rsp_fire) begin
                busy_q    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            mul_ctrl_q <= mul_ctrl_d;
            div_ctrl_q <= div_ctrl_d;
            src1_q     <= req_i.src1;
            src2_q     <= req_i.src2;
            tag_q      <= req_i.tag;
        end
    end

    assign mul_start_o = start_q && !sel_div_q;
    assign div_start_o = start_q && sel_div_q;
    assign mul_ctrl_o  = mul_ctrl_q;
    assign div_ctrl_o  = div_ctrl_q;
    assign src1_o      = src1_q;
    assign src2_o      = src2_q;

    // ------------------------------------------------------------------------
    // response
    // ------------------------------------------------------------------------
    assign unit_done   = sel_div_q ? div_done_i : mul_done_i;
    assign rsp_valid_o = busy_q && unit_done;
    assign rsp_fire    = rsp_valid_o && rsp_ready_i;
    assign mul_ack_o   = rsp_fire && !sel_div_q;
    assign div_ack_o   = rsp_fire && sel_div_q;

    always_comb begin
        rsp_o.rslt = sel_div_q ? div_rslt_i : mul_rslt_i;
        rsp_o.tag  = tag_q;
    end

endmodule

`default_nettype wire

// File: hdl/muldiv_unit.sv
// muldiv unit: RV32M multiply/divide execution unit with valid/ready request and response
`default_nettype none

module muldiv_unit
    import muldiv_op_pkg::*;
    import muldiv_bus_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst,
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  muldiv_req_t req_i,
    output logic        rsp_valid_o,
    input  logic        rsp_ready_i,
    output muldiv_rsp_t rsp_o
);

    logic        sreq_valid;   // input slice to dispatch
    logic        sreq_ready;
    muldiv_req_t sreq;
    logic        drsp_valid;   // dispatch to output slice
    logic        drsp_ready;
    muldiv_rsp_t drsp;

    logic        mul_start, mul_busy, mul_done, mul_ack;
    logic        div_start, div_busy, div_done, div_ack;
    mul_ctrl_t   mul_ctrl;
    div_ctrl_t   div_ctrl;
    xword_t      src1, src2;
    xword_t      mul_rslt, div_rslt;

    // ------------------------------------------------------------------------
    // request slice, dispatch, units, response slice
    // ------------------------------------------------------------------------
    pipe_slice #(.payload_t(muldiv_req_t)) req_slice (
        .clk_i, .rst,
        .in_valid_i (req_valid_i), .in_ready_o (req_ready_o), .in_data_i (req_i),
        .out_valid_o(sreq_valid),  .out_ready_i(sreq_ready),  .out_data_o(sreq)
    );

    muldiv_dispatch dispatch (
        .clk_i, .rst,
        .req_valid_i(sreq_valid), .req_ready_o(sreq_ready), .req_i(sreq),
        .mul_start_o(mul_start),  .mul_ctrl_o(mul_ctrl),
        .div_start_o(div_start),  .div_ctrl_o(div_ctrl),
        .src1_o(src1), .src2_o(src2),
        .mul_busy_i(mul_busy), .mul_done_i(mul_done), .mul_rslt_i(mul_rslt), .mul_ack_o(mul_ack),
        .div_busy_i(div_busy), .div_done_i(div_done), .div_rslt_i(div_rslt), .div_ack_o(div_ack),
        .rsp_valid_o(drsp_valid), .rsp_ready_i(drsp_ready), .rsp_o(drsp)
    );

    multiplier mul (
        .clk_i, .rst, .start_i(mul_start), .ctrl_i(mul_ctrl), .src1_i(src1), .src2_i(src2),
        .busy_o(mul_busy), .done_o(mul_done), .ack_i(mul_ack), .rslt_o(mul_rslt)
    );

    divider div (
        .clk_i, .rst, .start_i(div_start), .ctrl_i(div_ctrl), .src1_i(src1), .src2_i(src2),
        .busy_o(div_busy), .done_o(div_done), .ack_i(div_ack), .rslt_o(div_rslt)
    );

    pipe_slice #(.payload_t(muldiv_rsp_t)) rsp_slice (
        .clk_i, .rst,
        .in_valid_i (drsp_valid),  .in_ready_o (drsp_ready),  .in_data_i (drsp),
        .out_valid_o(rsp_valid_o), .out_ready_i(rsp_ready_i), .out_data_o(rsp_o)
    );

endmodule

`default_nettype wire

// File: tests/muldiv_unit_sva.sv
// muldiv unit assertions: handshake stability, reset state and divider latency
`default_nettype none

module muldiv_unit_sva
    import muldiv_bus_pkg::*;
(
    input logic        clk_i,
    input logic        rst,
    input logic        req_valid_i,
    input logic        req_ready_o,
    input muldiv_req_t req_i,
    input logic        rsp_valid_o,
    input logic        rsp_ready_i,
    input muldiv_rsp_t rsp_o,
    input logic        div_busy_i,
    input logic        div_done_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int div_run_q;   // busy cycles of the divider before its result
    int n_fail = 0;  // assertion failures, read by the testbench

    always_ff @(posedge clk_i) begin
        if (rst || !div_busy_i || div_done_i) begin
            div_run_q <= 0;
        end else begin
            div_run_q <= div_run_q + 1;
        end
    end

    // ------------------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------------------
    req_stable: assert property (@(posedge clk_i) disable iff (rst)
        req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i))
        else begin
            $error("req_i changed or req_valid_i dropped before the transfer");
            n_fail++;
        end

    rsp_stable: assert property (@(posedge clk_i) disable iff (rst)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
        else begin
            $error("rsp_o changed or rsp_valid_o dropped before the transfer");
            n_fail++;
        end

    rsp_idle_after_reset: assert property (@(posedge clk_i) rst |=> !rsp_valid_o)
        else begin
            $error("rsp_valid_o high in the cycle after reset");
            n_fail++;
        end

    // the return cycle adds one, so busy lasts at most 34 cycles
    div_latency: assert property (@(posedge clk_i) disable iff (rst) div_run_q < 34)
        else begin
            $error("divider busy for more than 34 cycles");
            n_fail++;
        end

endmodule

bind muldiv_unit muldiv_unit_sva sva (
    .clk_i      (clk_i),
    .rst        (rst),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_i      (req_i),
    .rsp_valid_o(rsp_valid_o),
    .rsp_ready_i(rsp_ready_i),
    .rsp_o      (rsp_o),
    .div_busy_i (div_busy),
    .div_done_i (div_done)
);

`default_nettype wire

// File: tests/muldiv_unit_tb.sv
// muldiv unit testbench: directed corners, random streams and back-pressure vs a reference model
`default_nettype none

module muldiv_unit_tb
    import muldiv_op_pkg::*;
    import muldiv_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED     = 32'h79ea;
    localparam int TIMEOUT  = 200;  // cycles allowed per wait
    localparam int N_RANDOM = 300;

    logic        clk_i;
    logic        rst;
    logic        req_valid_i;
    logic        req_ready_o;
    muldiv_req_t req_i;
    logic        rsp_valid_o;
    logic        rsp_ready_i;
    muldiv_rsp_t rsp_o;

    integer      seed;
    integer      bp_seed;
    logic        bp_on;       // random rsp_ready_i
    logic        ready_chk;   // watch req_ready_o while streaming
    bit          timed_out;
    int          n_err;
    int          n_sent;
    int          n_rsp;
    muldiv_req_t sent_q[$];   // accepted, not yet answered

    muldiv_unit dut (
        .clk_i      (clk_i),
        .rst        (rst),
        .req_valid_i(req_valid_i),
        .req_ready_o(req_ready_o),
        .req_i      (req_i),
        .rsp_valid_o(rsp_valid_o),
        .rsp_ready_i(rsp_ready_i),
        .rsp_o      (rsp_o)
    );

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // reference model, RV32M semantics
    // ------------------------------------------------------------------------
    function automatic xword_t ref_result(muldiv_op_e op, xword_t a, xword_t b);
        logic [63:0] a_s;
        logic [63:0] b_s;
        logic [63:0] prod;
        logic        ovf;
        xword_t      res;
        a_s  = {{32{a[31]}}, a};
        b_s  = {{32{b[31]}}, b};
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);  // most negative / -1
        prod = '0;
        res  = '0;
        case (op)
            OP_MUL:    res = a * b;
            OP_MULH:   prod = a_s * b_s;
            OP_MULHSU: prod = a_s * {32'h0, b};
            OP_MULHU:  prod = {32'h0, a} * {32'h0, b};
            OP_DIV: begin
                if (b == '0) res = '1;
                else if (ovf) res = a;
                else res = $signed(a) / $signed(b);
            end
            OP_DIVU: res = (b == '0) ? 32'hffff_ffff : a / b;
            OP_REM: begin
                if (b == '0) res = a;
                else if (ovf) res = '0;
                else res = $signed(a) % $signed(b);  // sign follows dividend
            end
            default: res = (b == '0) ? a : a % b;
        endcase
        if (op inside {OP_MULH, OP_MULHSU, OP_MULHU}) res = prod[63:32];
        return res;
    endfunction

    // corner values mixed into random operands
    function automatic xword_t pick_operand();
        case ($random(seed) & 7)
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return xword_t'($random(seed) & 15);
            default: return $random(seed);
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic send_req(input muldiv_op_e op, input xword_t a, input xword_t b);
        muldiv_req_t r;
        int          waited;
        r.op   = op;
        r.src1 = a;
        r.src2 = b;
        r.tag  = tag_t'(n_sent);
        waited = 0;
        if (timed_out) return;
        req_valid_i <= 1'b1;
        req_i       <= r;
        @(posedge clk_i);
        while (!req_ready_o && waited < TIMEOUT) begin  // ready seen before this edge
            waited++;
            @(posedge clk_i);
        end
        assert (req_ready_o) else begin
            $display("%0t: request %0d not accepted within %0d cycles", $time, n_sent, TIMEOUT);
            n_err++;
            timed_out = 1'b1;
        end
        if (!timed_out) begin
            sent_q.push_back(r);
            n_sent++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        int left;
        waited = 0;
        left   = sent_q.size();
        while (sent_q.size() != 0 && !timed_out) begin
            @(posedge clk_i);
            if (sent_q.size() != left) begin
                left   = sent_q.size();
                waited = 0;
            end else begin
                waited++;
                assert (waited < TIMEOUT) else begin
                    $display("%0t: no response within %0d cycles, %0d outstanding",
                             $time, TIMEOUT, left);
                    n_err++;
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    task automatic send_random(input int count);
        muldiv_op_e op;
        xword_t     a;
        xword_t     b;
        for (int i = 0; i < count && !timed_out; i++) begin
            op = muldiv_op_e'(3'($random(seed)));
            a  = pick_operand();
            b  = pick_operand();
            send_req(op, a, b);
        end
        req_valid_i <= 1'b0;
        wait_drain();
    endtask

    task automatic report_test(input string name, input int n_req, input int err_before);
        $display("test %s: %0d requests, %0d errors", name, n_req, n_err - err_before);
    endtask

    // ------------------------------------------------------------------------
    // response side
    // ------------------------------------------------------------------------
    task automatic compare_rsp(input muldiv_rsp_t rsp);
        muldiv_req_t r;
        xword_t      exp;
        n_rsp++;
        assert (sent_q.size() != 0) else begin
            $display("%0t: response with tag %h but no request outstanding", $time, rsp.tag);
            n_err++;
        end
        if (sent_q.size() != 0) begin
            r   = sent_q.pop_front();
            exp = ref_result(r.op, r.src1, r.src2);
            assert (rsp.tag == r.tag) else begin
                $display("mismatch at %0t: rsp_o.tag expected %h actual %h",
                         $time, r.tag, rsp.tag);
                n_err++;
            end
            assert (rsp.rslt == exp) else begin
                $display("mismatch at %0t: rsp_o.rslt (%s %h %h) expected %h actual %h",
                         $time, r.op.name(), r.src1, r.src2, exp, rsp.rslt);
                n_err++;
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst && rsp_valid_o && rsp_ready_i) begin
            compare_rsp(rsp_o);
        end
    end

    always @(posedge clk_i) begin
        if (bp_on) begin
            rsp_ready_i <= 1'($random(bp_seed));
        end else begin
            rsp_ready_i <= 1'b1;
        end
    end

    // a full input slice behind a busy dispatch means two requests in flight
    always @(posedge clk_i) begin
        if (ready_chk && !req_ready_o) begin
            assert (sent_q.size() >= 2) else begin
                $display("%0t: req_ready_o low with %0d requests outstanding",
                         $time, sent_q.size());
                n_err++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        int err0;
        int sent0;
        seed        = SEED;
        bp_seed     = SEED;
        bp_on       = 1'b0;
        ready_chk   = 1'b0;
        timed_out   = 1'b0;
        n_err       = 0;
        n_sent      = 0;
        n_rsp       = 0;
        rst         = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b1;
        repeat (10) @(posedge clk_i);
        rst <= 1'b0;
        @(posedge clk_i);

        err0 = n_err;
        assert (rsp_valid_o == 1'b0) else begin
            $display("mismatch at %0t: rsp_valid_o expected 0 actual %b", $time, rsp_valid_o);
            n_err++;
        end
        assert (req_ready_o == 1'b1) else begin
            $display("mismatch at %0t: req_ready_o expected 1 actual %b", $time, req_ready_o);
            n_err++;
        end
        report_test("reset", 0, err0);

        err0  = n_err;
        sent0 = n_sent;
        send_req(OP_DIV,    32'h0000_0007, 32'h0);        // divide by zero
        send_req(OP_DIVU,   32'hdead_beef, 32'h0);
        send_req(OP_REM,    32'h8000_0000, 32'h0);
        send_req(OP_REMU,   32'h1234_5678, 32'h0);
        send_req(OP_DIV,    32'h8000_0000, 32'hffff_ffff);  // signed overflow
        send_req(OP_REM,    32'h8000_0000, 32'hffff_ffff);
        send_req(OP_DIV,    32'hffff_fff9, 32'h0000_0002);  // -7 / 2 toward zero
        send_req(OP_REM,    32'hffff_fff9, 32'h0000_0002);
        send_req(OP_MULH,   32'hffff_fff9, 32'h0000_0003);
        send_req(OP_MULH,   32'h8000_0000, 32'h8000_0000);
        send_req(OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff);
        send_req(OP_MULHU,  32'hffff_ffff, 32'hffff_ffff);
        req_valid_i <= 1'b0;
        wait_drain();
        report_test("directed", n_sent - sent0, err0);

        err0  = n_err;
        sent0 = n_sent;
        send_random(N_RANDOM);
        report_test("random", n_sent - sent0, err0);

        err0  = n_err;
        sent0 = n_sent;
        bp_on <= 1'b1;
        send_random(100);
        bp_on <= 1'b0;
        report_test("backpressure", n_sent - sent0, err0);

        err0  = n_err;
        sent0 = n_sent;
        @(posedge clk_i);
        ready_chk <= 1'b1;
        send_random(60);
        ready_chk <= 1'b0;
        report_test("streaming", n_sent - sent0, err0);

        repeat (20) @(posedge clk_i);  // quiet time to catch stray responses
        assert (n_rsp == n_sent) else begin
            $display("%0d requests accepted but %0d responses received", n_sent, n_rsp);
            n_err++;
        end
        assert (dut.sva.n_fail == 0) else begin
            $display("%0d bound assertion failures", dut.sva.n_fail);
            n_err += dut.sva.n_fail;
        end
        $display("done: %0d requests, %0d responses, %0d errors", n_sent, n_rsp, n_err);
        if (n_err == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: muldiv_unit.f
+incdir+hdl
hdl/muldiv_op_pkg.sv
hdl/muldiv_bus_pkg.sv
hdl/pipe_slice.sv
hdl/multiplier.sv
hdl/divider.sv
hdl/muldiv_dispatch.sv
hdl/muldiv_unit.sv
tests/muldiv_unit_sva.sv
tests/muldiv_unit_tb.sv

// File: Makefile
# Verilator build and run of the muldiv unit testbench

TOP := muldiv_unit_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f muldiv_unit.f

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
